// File: src/fetchPkg.sv
`default_nettype none

package fetchPkg;

    localparam int XLEN       = 32;                   // data and address width
    localparam int IMEM_WORDS = 64;                   // program ROM size in words
    localparam int IMEM_AW    = $clog2(IMEM_WORDS);   // word index bits
    localparam int FQ_DEPTH   = 4;                    // default fetch queue depth

    localparam logic [XLEN-1:0] NOP_INSTR = 32'h0000_0013;  // addi x0,x0,0

    // RV32I major opcodes, bits [6:0]
    localparam logic [6:0] OP_REG    = 7'b0110011;    // add, sub, ...
    localparam logic [6:0] OP_IMM    = 7'b0010011;    // addi, slli, ...
    localparam logic [6:0] OP_LOAD   = 7'b0000011;    // lw, lb, ...
    localparam logic [6:0] OP_JALR   = 7'b1100111;
    localparam logic [6:0] OP_STORE  = 7'b0100011;    // sw, sb, ...
    localparam logic [6:0] OP_BRANCH = 7'b1100011;    // beq, blt, ...
    localparam logic [6:0] OP_LUI    = 7'b0110111;
    localparam logic [6:0] OP_AUIPC  = 7'b0010111;
    localparam logic [6:0] OP_JAL    = 7'b1101111;

    // immediate layout of a decoded word
    typedef enum logic [2:0] {
        FMT_R = 3'd0,    // no immediate
        FMT_I = 3'd1,    // imm[11:0] in [31:20]
        FMT_S = 3'd2,    // split over [31:25] and [11:7]
        FMT_B = 3'd3,    // S layout, scrambled, lsb 0
        FMT_U = 3'd4,    // upper 20 bits
        FMT_J = 3'd5     // 21 bit jump offset, lsb 0
    } immFmt_t;

    // one fetched word with its address
    typedef struct packed {
        logic [XLEN-1:0] pc;       // byte address of instr
        logic [XLEN-1:0] instr;    // raw instruction word
    } fetchEntry_t;

endpackage

`default_nettype wire

// File: src/fetchLink.sv
`timescale 1ns/1ns
`default_nettype none

interface fetchLink;

    import fetchPkg::*;

    logic        req;      // producer has entry on the bus
    logic        ack;      // consumer took it
    logic        flush;    // one cycle pulse, only with req and ack low
    fetchEntry_t entry;    // held while req is high

    modport producer (
        output req,
        output flush,
        output entry,
        input  ack
    );

    modport consumer (
        input  req,
        input  flush,
        input  entry,
        output ack
    );

endinterface

`default_nettype wire

// File: src/instrMem.sv
`timescale 1ns/1ns
`default_nettype none

module instrMem (
    input  logic [fetchPkg::XLEN-1:0] pc,
    output logic [fetchPkg::XLEN-1:0] instr
);

    import fetchPkg::*;

    logic [XLEN-1:0] rom [IMEM_WORDS];    // one entry per word

    // sum of 1..10, stored to 64(x0), read back and checked against 55
    initial begin
        for (int i = 0; i < IMEM_WORDS; i++) begin
            rom[i] = NOP_INSTR;             // fill the unused tail
        end
        rom[ 0] = 32'h0000_0093;    // 0x00  addi x1, x0, 0      i = 0
        rom[ 1] = 32'h0000_0113;    // 0x04  addi x2, x0, 0      sum = 0
        rom[ 2] = 32'h00A0_0193;    // 0x08  addi x3, x0, 10     limit
        rom[ 3] = 32'h0400_0213;    // 0x0c  addi x4, x0, 64     result address
        // loop
        rom[ 4] = 32'h0030_8A63;    // 0x10  beq  x1, x3, +20    to done
        rom[ 5] = 32'h0010_8093;    // 0x14  addi x1, x1, 1
        rom[ 6] = 32'h0011_0133;    // 0x18  add  x2, x2, x1
        rom[ 7] = 32'h0022_2023;    // 0x1c  sw   x2, 0(x4)
        rom[ 8] = 32'hFF1F_F06F;    // 0x20  jal  x0, -16        back to loop
        // done
        rom[ 9] = 32'h0002_2283;    // 0x24  lw   x5, 0(x4)
        rom[10] = 32'hFC92_8313;    // 0x28  addi x6, x5, -55    zero if sum ok
        rom[11] = 32'h0000_006F;    // 0x2c  jal  x0, 0          park here
    end

    // byte offset bits ignored, address wraps at the ROM size
    assign instr = rom[pc[IMEM_AW+1:2]];

endmodule

`default_nettype wire

// File: src/pcGen.sv
`timescale 1ns/1ns
`default_nettype none

module pcGen (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      redirReq,
    input  logic [fetchPkg::XLEN-1:0] redirPc,
    output logic                      redirAck,
    fetchLink.producer                fl
);

    import fetchPkg::*;

    logic [XLEN-1:0] pc;         // address of the word being offered
    logic [XLEN-1:0] instr;      // ROM word at pc
    logic            relWait;    // req dropped, waiting for ack to fall

    instrMem i_instrMem (
        .pc    (pc),
        .instr (instr)
    );

    assign fl.entry = '{pc: pc, instr: instr};   // steady while pc is held

    always_ff @(posedge clk) begin
        if (rst) begin
            pc       <= '0;
            fl.req   <= 1'b0;
            fl.flush <= 1'b0;
            relWait  <= 1'b0;
            redirAck <= 1'b0;
        end else begin
            fl.flush <= 1'b0;                    // pulse lasts one cycle
            if (redirAck && !redirReq) begin
                redirAck <= 1'b0;                // redirect phase 4
            end
            if (fl.req) begin
                if (fl.ack) begin                // queue took the word
                    fl.req  <= 1'b0;
                    relWait <= 1'b1;
                    pc      <= pc + XLEN'(4);
                end
            end else if (relWait) begin
                if (!fl.ack) begin
                    relWait <= 1'b0;             // link idle again
                end
            end else if (redirReq && !redirAck) begin
                // link is idle here, so no transfer gets cut short
                pc       <= redirPc;
                redirAck <= 1'b1;
                fl.flush <= 1'b1;                // drop queued old stream
            end else begin
                fl.req <= 1'b1;                  // offer next word
            end
        end
    end

endmodule

`default_nettype wire

// File: src/fetchQueue.sv
`timescale 1ns/1ns
`default_nettype none

module fetchQueue #(
    parameter int depth = fetchPkg::FQ_DEPTH
) (
    input  logic       clk,
    input  logic       rst,
    fetchLink.consumer inL,
    fetchLink.producer outL
);

    import fetchPkg::*;

    typedef logic [$clog2(depth)-1:0]   ptr_t;
    typedef logic [$clog2(depth+1)-1:0] cnt_t;

    fetchEntry_t mem [depth];    // entry storage
    ptr_t        wrPtr;          // next free slot
    ptr_t        rdPtr;          // head slot
    cnt_t        count;          // entries held
    logic        full;
    logic        empty;
    logic        push;           // take the incoming entry this cycle
    logic        pop;            // head captured downstream
    logic        doFlush;

    function automatic ptr_t nextPtr(input ptr_t p);
        return (p == ptr_t'(depth - 1)) ? '0 : p + 1'b1;   // wrap at depth
    endfunction

    assign full    = (count == cnt_t'(depth));
    assign empty   = (count == '0);
    assign push    = inL.req && !inL.ack && !full;       // full holds off the ack
    assign pop     = outL.req && outL.ack;
    assign doFlush = inL.flush && !inL.req && !inL.ack;  // input link idle only

    assign outL.entry = mem[rdPtr];    // head stays put while outL.req is high
    assign outL.flush = 1'b0;          // decoder keeps one entry, nothing to clear

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wrPtr] <= inL.entry;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wrPtr    <= '0;
            rdPtr    <= '0;
            count    <= '0;
            inL.ack  <= 1'b0;
            outL.req <= 1'b0;
        end else begin
            if (push) begin
                inL.ack <= 1'b1;
            end else if (inL.ack && !inL.req) begin
                inL.ack <= 1'b0;
            end
            if (doFlush) begin
                wrPtr    <= '0;
                rdPtr    <= '0;
                count    <= '0;
                outL.req <= 1'b0;    // an unacked head is withdrawn
            end else begin
                if (push) wrPtr <= nextPtr(wrPtr);
                if (pop)  rdPtr <= nextPtr(rdPtr);
                count <= count + cnt_t'(push) - cnt_t'(pop);
                if (pop) begin
                    outL.req <= 1'b0;
                end else if (!outL.req && !outL.ack && !empty) begin
                    outL.req <= 1'b1;    // offer the head
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: src/instrDecoder.sv
`timescale 1ns/1ns
`default_nettype none

module instrDecoder (
    input  logic                      clk,
    input  logic                      rst,
    fetchLink.consumer                dl,
    output logic                      outReq,
    input  logic                      outAck,
    output logic [fetchPkg::XLEN-1:0] outPc,
    output logic [fetchPkg::XLEN-1:0] outInstr,
    output fetchPkg::immFmt_t         outFmt,
    output logic [4:0]                outRd,
    output logic [4:0]                outRs1,
    output logic [4:0]                outRs2,
    output logic [fetchPkg::XLEN-1:0] outImm
);

    import fetchPkg::*;

    logic [XLEN-1:0] word;     // incoming raw instruction
    logic [6:0]      opcode;
    immFmt_t         fmt;
    logic [XLEN-1:0] imm;
    logic            idle;     // both handshakes fully closed
    logic            take;     // capture this cycle

    assign word   = dl.entry.instr;
    assign opcode = word[6:0];

    always_comb begin
        case (opcode)
            OP_REG:                    fmt = FMT_R;
            OP_IMM, OP_LOAD, OP_JALR:  fmt = FMT_I;
            OP_STORE:                  fmt = FMT_S;
            OP_BRANCH:                 fmt = FMT_B;
            OP_LUI, OP_AUIPC:          fmt = FMT_U;
            OP_JAL:                    fmt = FMT_J;
            default:                   fmt = FMT_R;    // unknown opcode
        endcase
    end

    always_comb begin
        case (fmt)
            FMT_I:   imm = {{20{word[31]}}, word[31:20]};
            FMT_S:   imm = {{20{word[31]}}, word[31:25], word[11:7]};
            FMT_B:   imm = {{19{word[31]}}, word[31], word[7], word[30:25],
                            word[11:8], 1'b0};
            FMT_U:   imm = {word[31:12], 12'b0};
            FMT_J:   imm = {{11{word[31]}}, word[31], word[19:12], word[20],
                            word[30:21], 1'b0};
            default: imm = '0;                          // R has no immediate
        endcase
    end

    assign idle = !outReq && !outAck && !dl.ack;
    assign take = idle && dl.req;

    always_ff @(posedge clk) begin
        if (rst) begin
            outReq <= 1'b0;
            dl.ack <= 1'b0;
        end else if (take) begin
            dl.ack <= 1'b1;
            outReq <= 1'b1;                  // fields valid from this edge
        end else begin
            if (dl.ack && !dl.req) begin
                dl.ack <= 1'b0;
            end
            if (outReq && outAck) begin
                outReq <= 1'b0;              // next take waits for outAck low
            end
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            outPc    <= dl.entry.pc;
            outInstr <= word;
            outFmt   <= fmt;
            outRd    <= word[11:7];
            outRs1   <= word[19:15];
            outRs2   <= word[24:20];
            outImm   <= imm;
        end
    end

endmodule

`default_nettype wire

// File: src/fetchDecodeTop.sv
`timescale 1ns/1ns
`default_nettype none

module fetchDecodeTop (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      redirReq,
    input  logic [fetchPkg::XLEN-1:0] redirPc,
    output logic                      redirAck,
    output logic                      outReq,
    input  logic                      outAck,
    output logic [fetchPkg::XLEN-1:0] outPc,
    output logic [fetchPkg::XLEN-1:0] outInstr,
    output fetchPkg::immFmt_t         outFmt,
    output logic [4:0]                outRd,
    output logic [4:0]                outRs1,
    output logic [4:0]                outRs2,
    output logic [fetchPkg::XLEN-1:0] outImm
);

    fetchLink fLink ();    // pc generator to queue
    fetchLink dLink ();    // queue to decoder

    pcGen i_pcGen (
        .clk      (clk),
        .rst      (rst),
        .redirReq (redirReq),
        .redirPc  (redirPc),
        .redirAck (redirAck),
        .fl       (fLink.producer)
    );

    fetchQueue i_fetchQueue (
        .clk  (clk),
        .rst  (rst),
        .inL  (fLink.consumer),
        .outL (dLink.producer)
    );

    instrDecoder i_instrDecoder (
        .clk      (clk),
        .rst      (rst),
        .dl       (dLink.consumer),
        .outReq   (outReq),
        .outAck   (outAck),
        .outPc    (outPc),
        .outInstr (outInstr),
        .outFmt   (outFmt),
        .outRd    (outRd),
        .outRs1   (outRs1),
        .outRs2   (outRs2),
        .outImm   (outImm)
    );

endmodule

`default_nettype wire

// File: tests/fetchDecode_chk.sv
`timescale 1ns/1ns
`default_nettype none

module fetchDecodeChk (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      redirReq,
    input  logic                      redirAck,
    input  logic                      outReq,
    input  logic                      outAck,
    input  logic [fetchPkg::XLEN-1:0] outPc,
    input  logic [fetchPkg::XLEN-1:0] outInstr,
    input  fetchPkg::immFmt_t         outFmt,
    input  logic [4:0]                outRd,
    input  logic [4:0]                outRs1,
    input  logic [4:0]                outRs2,
    input  logic [fetchPkg::XLEN-1:0] outImm,
    input  logic                      fReq,      // fetch link, pc generator side
    input  logic                      fAck,
    input  logic                      fFlush
);

    import fetchPkg::*;

    int errCount = 0;    // polled by the testbench

    // RV32I opcode to immediate layout
    function automatic immFmt_t fmtOf(input logic [31:0] w);
        case (w[6:0])
            7'b0110011:                         return FMT_R;
            7'b0010011, 7'b0000011, 7'b1100111: return FMT_I;
            7'b0100011:                         return FMT_S;
            7'b1100011:                         return FMT_B;
            7'b0110111, 7'b0010111:             return FMT_U;
            7'b1101111:                         return FMT_J;
            default:                            return FMT_R;
        endcase
    endfunction

    function automatic logic [31:0] immOf(input logic [31:0] w);
        case (fmtOf(w))
            FMT_I:   return 32'($signed(w[31:20]));
            FMT_S:   return 32'($signed({w[31:25], w[11:7]}));
            FMT_B:   return 32'($signed({w[31], w[7], w[30:25], w[11:8], 1'b0}));
            FMT_U:   return {w[31:12], 12'h000};
            FMT_J:   return 32'($signed({w[31], w[19:12], w[20], w[30:21], 1'b0}));
            default: return 32'h0;                  // R, no immediate
        endcase
    endfunction

    assert property (@(posedge clk) disable iff (rst) outReq && !outAck |=> outReq)
        else begin
            errCount++;
            $error("ERR %0t: outReq dropped before outAck", $time);
        end
    assert property (@(posedge clk) disable iff (rst)
        outReq && $past(outReq) |-> $stable({outPc, outInstr, outFmt, outRd, outRs1,
                                             outRs2, outImm}))
        else begin
            errCount++;
            $error("ERR %0t: output fields moved while outReq high", $time);
        end
    assert property (@(posedge clk) disable iff (rst) outAck && !outReq |=> !outReq)
        else begin
            errCount++;
            $error("ERR %0t: outReq rose again before outAck fell", $time);
        end
    assert property (@(posedge clk) disable iff (rst) $rose(redirAck) |-> redirReq)
        else begin
            errCount++;
            $error("ERR %0t: redirAck rose without redirReq", $time);
        end
    assert property (@(posedge clk) disable iff (rst) redirAck && redirReq |=> redirAck)
        else begin
            errCount++;
            $error("ERR %0t: redirAck dropped while redirReq high", $time);
        end
    // redirect only taken between fetch transfers
    assert property (@(posedge clk) disable iff (rst)
        $rose(redirAck) |-> !fReq && !fAck && $past(!fReq && !fAck))
        else begin
            errCount++;
            $error("ERR %0t: redirAck rose during an open fetch handshake", $time);
        end
    assert property (@(posedge clk) disable iff (rst) fFlush |-> !fReq && !fAck)
        else begin
            errCount++;
            $error("ERR %0t: flush while the fetch link was busy", $time);
        end
    assert property (@(posedge clk) disable iff (rst)
        outReq |-> outFmt == fmtOf(outInstr) && outImm == immOf(outInstr)
            && outRd == outInstr[11:7] && outRs1 == outInstr[19:15]
            && outRs2 == outInstr[24:20])
        else begin
            errCount++;
            $error("ERR %0t: bad decode of %h at pc %h", $time, outInstr, outPc);
        end

endmodule

bind fetchDecodeTop fetchDecodeChk i_chk (
    .*,
    .fReq   (fLink.req),
    .fAck   (fLink.ack),
    .fFlush (fLink.flush)
);

`default_nettype wire

// File: tests/fetchDecodeTb.sv
`timescale 1ns/1ns
`default_nettype none

module fetchDecodeTb;

    import fetchPkg::*;

    localparam int          CLK_PERIOD  = 100;
    localparam int          RST_CYCLES  = 16;
    localparam int          RUN_CYCLES  = 400;
    localparam int          DOG_CYCLES  = RUN_CYCLES + 100;    // run length plus slack
    localparam int          N_REDIRECTS = 6;
    localparam logic [31:0] SEED        = 32'h59d9_0483;

    logic            clk = 1'b0;
    logic            rst;
    logic            redirReq;
    logic [XLEN-1:0] redirPc;
    logic            redirAck;
    logic            outReq;
    logic            outAck;
    logic [XLEN-1:0] outPc;
    logic [XLEN-1:0] outInstr;
    immFmt_t         outFmt;
    logic [4:0]      outRd;
    logic [4:0]      outRs1;
    logic [4:0]      outRs2;
    logic [XLEN-1:0] outImm;

    int              cycle = 0;          // clocks since time 0
    int              outCount = 0;       // finished output handshakes
    logic [XLEN-1:0] expPc = '0;         // next pc of the running stream
    logic [XLEN-1:0] target;             // last accepted redirect
    logic            pending = 1'b0;     // target not seen at the output yet
    logic            oldSeen = 1'b0;     // the one old stream output is used up
    logic            ackPrev = 1'b0;

    fetchDecodeTop i_dut (.*);

    always #(CLK_PERIOD / 2) clk = ~clk;

    always @(posedge clk) cycle <= cycle + 1;

    task automatic stopWithFailure(input string msg);
        $display("%s", msg);
        $display("Simulation FAILED");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic sendRedirect(input logic [XLEN-1:0] dest);
        redirReq <= 1'b1;
        redirPc  <= dest;
        do @(posedge clk); while (!redirAck);
        redirReq <= 1'b0;
        do @(posedge clk); while (redirAck);    // phase 4 closes the handshake
    endtask

    initial begin : stimulus
        int              gap;
        logic [XLEN-1:0] dest;
        void'($urandom(SEED));
        rst      = 1'b1;
        redirReq = 1'b0;
        redirPc  = '0;
        repeat (RST_CYCLES) @(posedge clk);
        rst <= 1'b0;
        for (int i = 0; i < N_REDIRECTS; i++) begin
            gap = $urandom_range(48, 32);
            repeat (gap - 1) @(posedge clk);
            @(negedge clk);                                // expPc settled for this cycle
            do begin
                dest = 32'($urandom_range(63, 0)) << 2;    // word aligned, below 256
            end while (dest - expPc < 32);                 // clear of pcs in flight
            @(posedge clk);
            sendRedirect(dest);
        end
        while (cycle < RUN_CYCLES) @(posedge clk);
        @(negedge clk);                                    // last edge checks done
        if (i_dut.i_chk.errCount == 0 && !pending && outCount > 0) begin
            $display("Simulation PASSED");
            $finish;
        end else begin
            stopWithFailure($sformatf("ERR %0t: end of run with %0d outputs, target pending %0b",
                                      $time, outCount, pending));
        end
    end

    initial begin : ackDriver
        int delay;
        outAck = 1'b0;
        forever begin
            @(posedge clk);
            if (!rst && outReq && !outAck) begin
                delay = $urandom_range(6, 0);
                repeat (delay) @(posedge clk);
                outAck <= 1'b1;
                do @(posedge clk); while (outReq);    // req falls after the ack
                outAck <= 1'b0;
            end
        end
    end

    always @(posedge clk) begin : pcCheck
        if (rst) begin
            if (cycle > 0) begin
                assert (outReq === 1'b0 && redirAck === 1'b0)
                    else stopWithFailure($sformatf("ERR %0t: outReq or redirAck high in reset",
                                                   $time));
            end
        end else begin
            if (outReq && outAck) begin
                if (outCount == 0) begin
                    assert (outPc == '0)
                        else stopWithFailure($sformatf("ERR %0t: first pc %h, expected 0",
                                                       $time, outPc));
                end
                if (pending && outPc == target) begin
                    pending = 1'b0;                   // new stream reached the output
                    expPc   = target + 32'd4;
                end else begin
                    assert (outPc == expPc && !(pending && oldSeen))
                        else stopWithFailure($sformatf("ERR %0t: pc %h, expected %h or %h",
                                                       $time, outPc, expPc, target));
                    oldSeen = pending;                // one old entry may slip through
                    expPc   = expPc + 32'd4;
                end
                outCount++;
            end
            if (redirAck && !ackPrev) begin
                pending = 1'b1;
                oldSeen = 1'b0;
                target  = redirPc;
            end
        end
        ackPrev = redirAck;
    end

    always @(negedge clk) begin
        if (i_dut.i_chk.errCount != 0) begin
            stopWithFailure("a bound protocol or decode assertion failed");
        end
    end

    initial begin : watchdog
        #(DOG_CYCLES * CLK_PERIOD);
        stopWithFailure("watchdog expired before the run finished");
    end

endmodule

`default_nettype wire

// File: src.f
src/fetchPkg.sv
src/fetchLink.sv
src/instrMem.sv
src/pcGen.sv
src/fetchQueue.sv
src/instrDecoder.sv
src/fetchDecodeTop.sv
tests/fetchDecode_chk.sv
tests/fetchDecodeTb.sv

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module fetchDecodeTb -f src.f \
    || { echo "build failed"; exit 1; }
out=$(./obj_dir/VfetchDecodeTb +verilator+error+limit+10 2>&1)
echo "$out"
echo "$out" | grep -q "Simulation PASSED" \
    && echo "run.sh: test passed" \
    || { echo "run.sh: test failed"; exit 1; }
